// File: hw/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    localparam int XLEN     = 32;
    localparam int NUM_REGS = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      regaddr_t;
    typedef logic [2:0]      funct3_t;

    // base opcodes, bits [6:0] of the instruction
    typedef enum logic [6:0] {
        OP_LOAD     = 7'b0000011,
        OP_MISC_MEM = 7'b0001111,   // fence
        OP_IMM      = 7'b0010011,
        OP_AUIPC    = 7'b0010111,
        OP_STORE    = 7'b0100011,
        OP          = 7'b0110011,
        OP_LUI      = 7'b0110111,
        OP_BRANCH   = 7'b1100011,
        OP_JALR     = 7'b1100111,
        OP_JAL      = 7'b1101111,
        OP_SYSTEM   = 7'b1110011    // no row in the decode table, always halts
    } opcode_e;

    // branch conditions, bit 0 inverts the compare
    localparam funct3_t F3_BEQ  = 3'b000;
    localparam funct3_t F3_BNE  = 3'b001;
    localparam funct3_t F3_BLT  = 3'b100;
    localparam funct3_t F3_BGE  = 3'b101;
    localparam funct3_t F3_BLTU = 3'b110;
    localparam funct3_t F3_BGEU = 3'b111;

    // shift right, funct7 bit 5 picks arithmetic
    localparam funct3_t F3_SRL_SRA = 3'b101;

    // bubble is addi x0, x0, 0
    localparam word_t NOP_IR = 32'h0000_0013;
    localparam word_t NOP_PC = 32'h0000_0000;

    localparam word_t INSTR_BYTES = 32'd4;   // no compressed instructions

endpackage

`default_nettype wire

// File: hw/id_ctrl_pkg.sv
`default_nettype none

package id_ctrl_pkg;

    import rv_isa_pkg::*;

    // {funct7[0], funct7[5], funct3} for register ops, plus two internal modes
    typedef enum logic [4:0] {
        ALU_ADD   = 5'b00000,
        ALU_SLL   = 5'b00001,
        ALU_SLT   = 5'b00010,
        ALU_SLTU  = 5'b00011,
        ALU_XOR   = 5'b00100,
        ALU_SRL   = 5'b00101,
        ALU_OR    = 5'b00110,
        ALU_AND   = 5'b00111,
        ALU_SUB   = 5'b01000,
        ALU_SRA   = 5'b01101,
        ALU_COPY1 = 5'b11110,   // pass op1 through, used by lui
        ALU_X     = 5'b11111
    } alu_mode_e;

    typedef enum logic [1:0] {PC_NEXT, PC_JUMP_REL, PC_JUMP_ABS, PC_BRANCH} pc_mode_e;
    typedef enum logic [1:0] {OP1_X, OP1_RS1, OP1_IMMU} op1_sel_e;
    typedef enum logic [2:0] {OP2_X, OP2_RS2, OP2_IMMI, OP2_IMMS, OP2_PC} op2_sel_e;
    typedef enum logic [1:0] {MA_X, MA_LOAD, MA_STORE} ma_mode_e;
    typedef enum logic [1:0] {WB_SRC_X, WB_SRC_ALU, WB_SRC_PC4, WB_SRC_MEM} wb_src_e;

    typedef logic [2:0] ma_size_t;  // funct3 of the load or store
    localparam ma_size_t MA_SIZE_X = 3'b000;

    typedef struct packed {
        logic      halt;
        pc_mode_e  pc_mode;
        op1_sel_e  op1_sel;
        op2_sel_e  op2_sel;
        alu_mode_e alu_mode;
        ma_mode_e  ma_mode;
        ma_size_t  ma_size;
        wb_src_e   wb_src;
        logic      ra_used;
        logic      rb_used;
    } ctrl_word_t;

    typedef struct packed {
        word_t i;
        word_t s;
        word_t b;
        word_t u;
        word_t j;
    } imm_set_t;

    typedef struct packed {
        regaddr_t rs1;
        regaddr_t rs2;
        regaddr_t rd;
        funct3_t  funct3;
    } reg_fields_t;

    // one forwarding source, ready means data is final
    typedef struct packed {
        logic     valid;
        logic     ready;
        regaddr_t addr;
        word_t    data;
    } fwd_port_t;

    typedef struct packed {
        logic     valid;
        regaddr_t addr;
        word_t    data;
    } wb_port_t;

    typedef struct packed {
        word_t     pc;
        word_t     ir;
        word_t     alu_op1;
        word_t     alu_op2;
        alu_mode_e alu_mode;
        ma_mode_e  ma_mode;
        ma_size_t  ma_size;
        word_t     ma_data;     // store data
        wb_src_e   wb_src;
        word_t     wb_data;     // link address
        logic      wb_valid;
        logic      halt;
    } id_out_t;

    localparam id_out_t NOP_OUT = '{
        pc:       NOP_PC,
        ir:       NOP_IR,
        alu_op1:  '0,
        alu_op2:  '0,
        alu_mode: ALU_ADD,
        ma_mode:  MA_X,
        ma_size:  MA_SIZE_X,
        ma_data:  '0,
        wb_src:   WB_SRC_ALU,
        wb_data:  '0,
        wb_valid: 1'b0,     // rd is x0
        halt:     1'b0
    };

endpackage

`default_nettype wire

// File: hw/id_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module id_decoder
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire word_t ir_i,
    output ctrl_word_t  ctrl_o,
    output reg_fields_t fields_o,
    output imm_set_t    imm_o
);

    opcode_e    opcode;
    funct3_t    f3;
    logic [6:0] f7;
    alu_mode_e  mode7;     // register-register style mode
    alu_mode_e  mode3;     // funct3 only
    ctrl_word_t cw;

    always_comb begin
        opcode = opcode_e'(ir_i[6:0]);
        f3     = ir_i[14:12];
        f7     = ir_i[31:25];

        fields_o = '{rs1: ir_i[19:15], rs2: ir_i[24:20], rd: ir_i[11:7], funct3: f3};

        imm_o.i = {{20{ir_i[31]}}, ir_i[31:20]};
        imm_o.s = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
        imm_o.b = {{19{ir_i[31]}}, ir_i[31], ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
        imm_o.u = {ir_i[31:12], 12'b0};
        imm_o.j = {{11{ir_i[31]}}, ir_i[31], ir_i[19:12], ir_i[20], ir_i[30:21], 1'b0};

        mode7 = alu_mode_e'({f7[0], f7[5], f3});
        mode3 = alu_mode_e'({2'b00, f3});
    end

    // halt, pc_mode, op1, op2, alu_mode, ma_mode, ma_size, wb_src, ra_used, rb_used
    always_comb begin
        casez ({f7, f3, opcode})
            // shifts first so srai keeps funct7 bit 5
            {7'b0?00000, F3_SRL_SRA, OP_IMM}: cw = '{1'b0, PC_NEXT, OP1_RS1, OP2_IMMI, mode7,
                                                   MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b1, 1'b0};
            {7'b???????, 3'b???, OP_IMM}: cw = '{1'b0, PC_NEXT, OP1_RS1, OP2_IMMI, mode3,
                                               MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b1, 1'b0};
            {7'b???????, 3'b???, OP_LUI}: cw = '{1'b0, PC_NEXT, OP1_IMMU, OP2_X, ALU_COPY1,
                                               MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b0, 1'b0};
            {7'b???????, 3'b???, OP_AUIPC}: cw = '{1'b0, PC_NEXT, OP1_IMMU, OP2_PC, ALU_ADD,
                                                 MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b0, 1'b0};
            // only sub and sra take the alternate funct7
            {7'b0000000, 3'b???, OP},
            {7'b0100000, 3'b000, OP},
            {7'b0100000, F3_SRL_SRA, OP}: cw = '{1'b0, PC_NEXT, OP1_RS1, OP2_RS2, mode7,
                                               MA_X, MA_SIZE_X, WB_SRC_ALU, 1'b1, 1'b1};
            {7'b???????, 3'b???, OP_JAL}: cw = '{1'b0, PC_JUMP_REL, OP1_X, OP2_X, ALU_X,
                                               MA_X, MA_SIZE_X, WB_SRC_PC4, 1'b0, 1'b0};
            {7'b???????, 3'b???, OP_JALR}: cw = '{1'b0, PC_JUMP_ABS, OP1_X, OP2_X, ALU_X,
                                                MA_X, MA_SIZE_X, WB_SRC_PC4, 1'b1, 1'b0};
            {7'b???????, 3'b00?, OP_BRANCH},
            {7'b???????, 3'b1??, OP_BRANCH}: cw = '{1'b0, PC_BRANCH, OP1_X, OP2_X, ALU_X,
                                                  MA_X, MA_SIZE_X, WB_SRC_X, 1'b1, 1'b1};
            {7'b???????, 3'b???, OP_LOAD}: cw = '{1'b0, PC_NEXT, OP1_RS1, OP2_IMMI, ALU_ADD,
                                                MA_LOAD, ma_size_t'(f3), WB_SRC_MEM, 1'b1, 1'b0};
            {7'b???????, 3'b???, OP_STORE}: cw = '{1'b0, PC_NEXT, OP1_RS1, OP2_IMMS, ALU_ADD,
                                                 MA_STORE, ma_size_t'(f3), WB_SRC_X, 1'b1, 1'b1};
            {7'b???????, 3'b???, OP_MISC_MEM}: cw = '{1'b0, PC_NEXT, OP1_X, OP2_X, ALU_X,
                                                    MA_X, MA_SIZE_X, WB_SRC_X, 1'b0, 1'b0};
            // illegal encodings and the whole system opcode
            default: cw = '{1'b1, PC_NEXT, OP1_X, OP2_X, ALU_X,
                            MA_X, MA_SIZE_X, WB_SRC_X, 1'b0, 1'b0};
        endcase
    end

    // x0 is never a real dependency
    always_comb begin
        ctrl_o         = cw;
        ctrl_o.ra_used = cw.ra_used && (fields_o.rs1 != '0);
        ctrl_o.rb_used = cw.rb_used && (fields_o.rs2 != '0);
    end

    always_comb begin
        assert final (!ctrl_o.halt || ctrl_o.wb_src == WB_SRC_X)
            else $error("halted instruction requests a register write-back");
    end

endmodule

`default_nettype wire

// File: hw/id_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module id_regfile
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire logic     clk_i,
    input  wire regaddr_t rd1_addr_i,
    input  wire regaddr_t rd2_addr_i,
    output word_t         rd1_data_o,
    output word_t         rd2_data_o,
    input  wire wb_port_t wr_i
);

    word_t regs [1:NUM_REGS-1];   // no storage behind x0

    always_ff @(posedge clk_i) begin
        if (wr_i.valid && wr_i.addr != '0) begin
            regs[wr_i.addr] <= wr_i.data;
        end
    end

    // async reads, x0 hardwired
    always_comb begin
        rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];
        rd2_data_o = (rd2_addr_i == '0) ? '0 : regs[rd2_addr_i];
    end

    // x0 stays zero even right after a write addressed to it
    assert property (@(posedge clk_i)
        (rd1_addr_i == '0 |-> rd1_data_o == '0) and (rd2_addr_i == '0 |-> rd2_data_o == '0))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// File: hw/id_operand_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module id_operand_bypass
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire reg_fields_t fields_i,
    input  wire ctrl_word_t  ctrl_i,
    input  wire word_t       ra_raw_i,
    input  wire word_t       rb_raw_i,
    input  wire fwd_port_t   ex_fwd_i,
    input  wire fwd_port_t   ma_fwd_i,
    input  wire wb_port_t    wb_i,
    output word_t            ra_o,
    output word_t            rb_o,
    output logic             hazard_o
);

    // youngest producer wins
    function automatic word_t forward(regaddr_t rs, word_t raw, fwd_port_t ex,
                                      fwd_port_t ma, wb_port_t wb);
        word_t val;
        if (rs == '0)
            val = raw;
        else if (ex.valid && ex.addr == rs)
            val = ex.data;
        else if (ma.valid && ma.addr == rs)
            val = ma.data;
        else if (wb.valid && wb.addr == rs)
            val = wb.data;
        else
            val = raw;
        return val;
    endfunction

    // destination matches but the value is still in flight
    function automatic logic pending(regaddr_t rs, fwd_port_t src);
        return src.valid && !src.ready && src.addr == rs;
    endfunction

    logic ra_stall;
    logic rb_stall;

    always_comb begin
        ra_o = forward(fields_i.rs1, ra_raw_i, ex_fwd_i, ma_fwd_i, wb_i);
        rb_o = forward(fields_i.rs2, rb_raw_i, ex_fwd_i, ma_fwd_i, wb_i);

        // used flags are already cleared for x0
        ra_stall = ctrl_i.ra_used &&
                   (pending(fields_i.rs1, ex_fwd_i) || pending(fields_i.rs1, ma_fwd_i));
        rb_stall = ctrl_i.rb_used &&
                   (pending(fields_i.rs2, ex_fwd_i) || pending(fields_i.rs2, ma_fwd_i));
        hazard_o = ra_stall || rb_stall;
    end

endmodule

`default_nettype wire

// File: hw/id_branch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module id_branch_unit
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire logic       reset_i,
    input  wire ctrl_word_t ctrl_i,
    input  wire funct3_t    funct3_i,
    input  wire word_t      pc_i,
    input  wire imm_set_t   imm_i,
    input  wire word_t      ra_i,
    input  wire word_t      rb_i,
    input  wire logic       hazard_i,
    output logic            jmp_valid_o,
    output word_t           jmp_addr_o
);

    logic cond;
    logic taken;

    always_comb begin
        case (funct3_i)
            F3_BEQ, F3_BNE:   cond = (ra_i == rb_i);
            F3_BLT, F3_BGE:   cond = ($signed(ra_i) < $signed(rb_i));
            F3_BLTU, F3_BGEU: cond = (ra_i < rb_i);
            default:          cond = 1'b0;
        endcase
        taken = cond ^ funct3_i[0];   // odd codes are the negated forms
    end

    always_comb begin
        case (ctrl_i.pc_mode)
            PC_JUMP_REL: begin
                jmp_valid_o = 1'b1;     // target needs no register
                jmp_addr_o  = pc_i + imm_i.j;
            end
            PC_JUMP_ABS: begin
                jmp_valid_o = !hazard_i;
                jmp_addr_o  = ra_i + imm_i.i;
            end
            PC_BRANCH: begin
                jmp_valid_o = taken && !hazard_i;
                jmp_addr_o  = pc_i + imm_i.b;
            end
            default: begin
                jmp_valid_o = 1'b0;
                jmp_addr_o  = '0;
            end
        endcase

        // fetch must not redirect while the pipe comes out of reset
        if (reset_i) begin
            jmp_valid_o = 1'b0;
            jmp_addr_o  = '0;
        end
    end

    always_comb begin
        assert final (!jmp_valid_o || ctrl_i.pc_mode != PC_NEXT)
            else $error("jump raised for a sequential instruction");
    end

endmodule

`default_nettype wire

// File: hw/id_issue.sv
`timescale 1ns/1ps
`default_nettype none

module id_issue
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire logic       clk_i,
    input  wire logic       reset_i,
    input  wire word_t      pc_i,
    input  wire word_t      ir_i,
    input  wire ctrl_word_t ctrl_i,
    input  wire regaddr_t   rd_i,
    input  wire imm_set_t   imm_i,
    input  wire word_t      ra_i,
    input  wire word_t      rb_i,
    input  wire logic       hazard_i,
    output logic            ready_o,
    output id_out_t         out_o
);

    word_t   op1;
    word_t   op2;
    logic    wb_valid;
    id_out_t decoded;

    always_comb begin
        case (ctrl_i.op1_sel)
            OP1_RS1:  op1 = ra_i;
            OP1_IMMU: op1 = imm_i.u;
            default:  op1 = '0;
        endcase

        case (ctrl_i.op2_sel)
            OP2_RS2:  op2 = rb_i;
            OP2_IMMI: op2 = imm_i.i;
            OP2_IMMS: op2 = imm_i.s;
            OP2_PC:   op2 = pc_i;
            default:  op2 = '0;
        endcase

        wb_valid = (ctrl_i.wb_src != WB_SRC_X) && (rd_i != '0);   // writes to x0 dropped here

        decoded = '{
            pc:       pc_i,
            ir:       ir_i,
            alu_op1:  op1,
            alu_op2:  op2,
            alu_mode: ctrl_i.alu_mode,
            ma_mode:  ctrl_i.ma_mode,
            ma_size:  ctrl_i.ma_size,
            ma_data:  rb_i,
            wb_src:   ctrl_i.wb_src,
            wb_data:  pc_i + INSTR_BYTES,
            wb_valid: wb_valid,
            halt:     ctrl_i.halt
        };
    end

    // fetch holds pc/ir while not ready, so the stalled instruction issues later
    assign ready_o = reset_i || !hazard_i;

    always_ff @(posedge clk_i) begin
        if (reset_i || hazard_i)
            out_o <= NOP_OUT;   // bubble
        else
            out_o <= decoded;
    end

    assert property (@(posedge clk_i) disable iff (reset_i) hazard_i |=> !out_o.wb_valid)
        else $error("stalled cycle issued a register write");

endmodule

`default_nettype wire

// File: hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      reset_i,
    input  wire word_t     pc_i,
    input  wire word_t     ir_i,
    input  wire fwd_port_t ex_fwd_i,
    input  wire fwd_port_t ma_fwd_i,
    input  wire wb_port_t  wb_i,
    output logic           ready_o,
    output logic           jmp_valid_o,
    output word_t          jmp_addr_o,
    output id_out_t        out_o
);

    ctrl_word_t  ctrl;
    reg_fields_t fields;
    imm_set_t    imm;
    word_t       ra_raw;
    word_t       rb_raw;
    word_t       ra_fwd;     // after bypass
    word_t       rb_fwd;
    logic        hazard;

    id_decoder i_decoder (
        .ir_i     (ir_i),
        .ctrl_o   (ctrl),
        .fields_o (fields),
        .imm_o    (imm)
    );

    // wb_i writes here and is forwarded in the same cycle
    id_regfile i_regfile (
        .clk_i      (clk_i),
        .rd1_addr_i (fields.rs1),
        .rd2_addr_i (fields.rs2),
        .rd1_data_o (ra_raw),
        .rd2_data_o (rb_raw),
        .wr_i       (wb_i)
    );

    id_operand_bypass i_bypass (
        .fields_i (fields),
        .ctrl_i   (ctrl),
        .ra_raw_i (ra_raw),
        .rb_raw_i (rb_raw),
        .ex_fwd_i (ex_fwd_i),
        .ma_fwd_i (ma_fwd_i),
        .wb_i     (wb_i),
        .ra_o     (ra_fwd),
        .rb_o     (rb_fwd),
        .hazard_o (hazard)
    );

    id_branch_unit i_branch (
        .reset_i     (reset_i),
        .ctrl_i      (ctrl),
        .funct3_i    (fields.funct3),
        .pc_i        (pc_i),
        .imm_i       (imm),
        .ra_i        (ra_fwd),
        .rb_i        (rb_fwd),
        .hazard_i    (hazard),
        .jmp_valid_o (jmp_valid_o),
        .jmp_addr_o  (jmp_addr_o)
    );

    id_issue i_issue (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .pc_i     (pc_i),
        .ir_i     (ir_i),
        .ctrl_i   (ctrl),
        .rd_i     (fields.rd),
        .imm_i    (imm),
        .ra_i     (ra_fwd),
        .rb_i     (rb_fwd),
        .hazard_i (hazard),
        .ready_o  (ready_o),
        .out_o    (out_o)
    );

endmodule

`default_nettype wire

// File: tests/id_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb
    import rv_isa_pkg::*;
    import id_ctrl_pkg::*;
();

    localparam int MAX_CYCLES = 1000;

    logic      clk;
    logic      reset;
    word_t     pc;
    word_t     ir;
    fwd_port_t ex_fwd;
    fwd_port_t ma_fwd;
    wb_port_t  wb;
    logic      ready;
    logic      jmp_valid;
    word_t     jmp_addr;
    id_out_t   dut_out;

    word_t model [0:NUM_REGS-1];   // register contents as written through wb
    word_t seed = 32'headd_67b8;
    int    errors = 0;
    int    checks = 0;
    int    cycles = 0;

    id_stage i_dut (
        .clk_i       (clk),
        .reset_i     (reset),
        .pc_i        (pc),
        .ir_i        (ir),
        .ex_fwd_i    (ex_fwd),
        .ma_fwd_i    (ma_fwd),
        .wb_i        (wb),
        .ready_o     (ready),
        .jmp_valid_o (jmp_valid),
        .jmp_addr_o  (jmp_addr),
        .out_o       (dut_out)
    );

    always #4 clk = ~clk;

    function automatic word_t next_rand();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, regaddr_t rs1, funct3_t f3,
                                    regaddr_t rd, opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_r(logic [6:0] f7, regaddr_t rs2, regaddr_t rs1,
                                    funct3_t f3, regaddr_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, regaddr_t rs2, regaddr_t rs1, funct3_t f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(logic [12:0] off, regaddr_t rs2, regaddr_t rs1, funct3_t f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_j(logic [20:0] off, regaddr_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, OP_JAL};
    endfunction

    // branch outcome straight from the ISA definitions
    function automatic logic branch_taken(funct3_t f3, word_t a, word_t b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            F3_BGEU: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // plain ALU-style instruction with rs2 read back as store data
    function automatic id_out_t expected_out(word_t pc_v, word_t ir_v, word_t op1, word_t op2,
                                             alu_mode_e mode, wb_src_e src);
        id_out_t e;
        e = '{pc: pc_v, ir: ir_v, alu_op1: op1, alu_op2: op2, alu_mode: mode,
              ma_mode: MA_X, ma_size: 3'b000, ma_data: model[ir_v[24:20]],
              wb_src: src, wb_data: pc_v + 32'd4,
              wb_valid: (src != WB_SRC_X) && (ir_v[11:7] != 5'd0), halt: 1'b0};
        return e;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERR %s got %h exp %h", name, got, exp);
        end
    endtask

    task automatic check_out(string name, id_out_t got, id_out_t exp);
        check_word({name, ".pc"}, got.pc, exp.pc);
        check_word({name, ".ir"}, got.ir, exp.ir);
        check_word({name, ".alu_op1"}, got.alu_op1, exp.alu_op1);
        check_word({name, ".alu_op2"}, got.alu_op2, exp.alu_op2);
        check_word({name, ".ma_data"}, got.ma_data, exp.ma_data);
        check_word({name, ".wb_data"}, got.wb_data, exp.wb_data);
        check_bit({name, ".wb_valid"}, got.wb_valid, exp.wb_valid);
        check_bit({name, ".halt"}, got.halt, exp.halt);
        checks += 4;
        if (got.alu_mode !== exp.alu_mode) begin
            errors++;
            $display("ERR %s.alu_mode got %h exp %h", name, got.alu_mode, exp.alu_mode);
        end
        if (got.ma_mode !== exp.ma_mode) begin
            errors++;
            $display("ERR %s.ma_mode got %h exp %h", name, got.ma_mode, exp.ma_mode);
        end
        if (got.ma_size !== exp.ma_size) begin
            errors++;
            $display("ERR %s.ma_size got %h exp %h", name, got.ma_size, exp.ma_size);
        end
        if (got.wb_src !== exp.wb_src) begin
            errors++;
            $display("ERR %s.wb_src got %h exp %h", name, got.wb_src, exp.wb_src);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // drive fetch and let the combinational paths settle
    task automatic present(word_t pc_v, word_t ir_v);
        pc = pc_v;
        ir = ir_v;
        #1;
    endtask

    task automatic wait_ready();
        #1;
        while (!ready) begin
            next_cycle();
            #1;
        end
    endtask

    task automatic write_reg(regaddr_t addr, word_t data);
        wb = '{valid: 1'b1, addr: addr, data: data};
        next_cycle();
        wb = '0;
        if (addr != 5'd0)
            model[addr] = data;
    endtask

    task automatic test_reset();
        ir = enc_j(21'h000100, 5'd1);   // jump held while in reset
        repeat (10) @(posedge clk);
        #1;
        check_bit("ready_o", ready, 1'b1);
        check_bit("jmp_valid_o", jmp_valid, 1'b0);
        check_word("jmp_addr_o", jmp_addr, '0);
        reset = 1'b0;
        ir = NOP_IR;
        check_out("out_o", dut_out, NOP_OUT);
        #1;
        check_bit("ready_o", ready, 1'b1);
        check_bit("jmp_valid_o", jmp_valid, 1'b0);
        next_cycle();
    endtask

    task automatic fill_regs();
        model[0] = '0;
        for (int i = 1; i < NUM_REGS; i++) begin
            write_reg(regaddr_t'(i), next_rand());
        end
    endtask

    task automatic run_alu(word_t pc_v, word_t ir_v, word_t op1, word_t op2, alu_mode_e mode);
        present(pc_v, ir_v);
        check_bit("ready_o", ready, 1'b1);
        next_cycle();
        check_out("out_o", dut_out, expected_out(pc_v, ir_v, op1, op2, mode, WB_SRC_ALU));
    endtask

    task automatic test_alu();
        run_alu(32'h100, enc_i(12'hffd, 5'd5, 3'b000, 5'd7, OP_IMM),
                model[5], 32'hffff_fffd, ALU_ADD);
        run_alu(32'h104, enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd8), model[5], model[6], ALU_ADD);
        run_alu(32'h108, enc_i(12'h407, 5'd5, F3_SRL_SRA, 5'd9, OP_IMM),
                model[5], 32'h0000_0407, ALU_SRA);
        run_alu(32'h10c, {20'h12345, 5'd10, OP_LUI}, 32'h1234_5000, '0, ALU_COPY1);
        run_alu(32'h110, {20'habcde, 5'd11, OP_AUIPC}, 32'habcd_e000, 32'h110, ALU_ADD);
        run_alu(32'h114, enc_i(12'h001, 5'd5, 3'b000, 5'd0, OP_IMM),
                model[5], 32'h1, ALU_ADD);   // rd x0 so no write-back
    endtask

    task automatic test_forwarding();
        word_t ex_val;
        word_t ma_val;
        word_t wb_val;
        ex_val = next_rand();
        ma_val = next_rand();
        wb_val = next_rand();
        ex_fwd = '{valid: 1'b1, ready: 1'b1, addr: 5'd5, data: ex_val};
        ma_fwd = '{valid: 1'b1, ready: 1'b1, addr: 5'd5, data: ma_val};
        wb = '{valid: 1'b1, addr: 5'd5, data: wb_val};
        present(32'h200, enc_i(12'h000, 5'd5, 3'b000, 5'd12, OP_IMM));
        check_bit("ready_o", ready, 1'b1);
        next_cycle();
        model[5] = wb_val;   // wb landed at that edge
        check_word("out_o.alu_op1", dut_out.alu_op1, ex_val);
        ex_fwd = '0;
        next_cycle();
        check_word("out_o.alu_op1", dut_out.alu_op1, ma_val);
        // new wb data while the register file still holds the old value
        wb_val = next_rand();
        ma_fwd = '0;
        wb.data = wb_val;
        next_cycle();
        check_word("out_o.alu_op1", dut_out.alu_op1, wb_val);
        model[5] = wb_val;
        wb = '0;
        next_cycle();
        check_word("out_o.alu_op1", dut_out.alu_op1, model[5]);
        // x0 must ignore every forwarding source
        ex_fwd = '{valid: 1'b1, ready: 1'b1, addr: 5'd0, data: ex_val};
        ma_fwd = '{valid: 1'b1, ready: 1'b1, addr: 5'd0, data: ma_val};
        wb = '{valid: 1'b1, addr: 5'd0, data: wb_val};
        present(32'h204, enc_i(12'h007, 5'd0, 3'b000, 5'd13, OP_IMM));
        next_cycle();
        check_word("out_o.alu_op1", dut_out.alu_op1, '0);
        check_word("out_o.alu_op2", dut_out.alu_op2, 32'h7);
        ex_fwd = '0;
        ma_fwd = '0;
        wb = '0;
    endtask

    task automatic test_hazard();
        word_t ex_val;
        word_t ir_v;
        ex_val = next_rand();
        ir_v = enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd14);
        ex_fwd = '{valid: 1'b1, ready: 1'b0, addr: 5'd5, data: ex_val};
        present(32'h300, ir_v);
        check_bit("ready_o", ready, 1'b0);
        repeat (2) begin
            next_cycle();
            check_out("out_o", dut_out, NOP_OUT);   // bubble
        end
        ex_fwd.ready = 1'b1;
        wait_ready();
        next_cycle();
        check_out("out_o", dut_out, expected_out(32'h300, ir_v, ex_val, model[6], ALU_ADD,
                                                 WB_SRC_ALU));
        ex_fwd = '0;
    endtask

    task automatic test_jumps();
        word_t ir_v;
        present(32'h2000, enc_j(21'h000800, 5'd1));
        check_bit("jmp_valid_o", jmp_valid, 1'b1);
        check_word("jmp_addr_o", jmp_addr, 32'h2800);
        next_cycle();
        check_word("out_o.wb_data", dut_out.wb_data, 32'h2004);
        check_bit("out_o.wb_valid", dut_out.wb_valid, 1'b1);
        ir_v = enc_i(12'hff8, 5'd5, 3'b000, 5'd1, OP_JALR);
        present(32'h2004, ir_v);
        check_bit("jmp_valid_o", jmp_valid, 1'b1);
        check_word("jmp_addr_o", jmp_addr, model[5] + 32'hffff_fff8);
        next_cycle();
        // base register still in EX
        ex_fwd = '{valid: 1'b1, ready: 1'b0, addr: 5'd5, data: 32'h1234_5678};
        present(32'h2008, ir_v);
        check_bit("jmp_valid_o", jmp_valid, 1'b0);
        check_bit("ready_o", ready, 1'b0);
        next_cycle();
        ex_fwd = '0;
    endtask

    task automatic test_branches();
        funct3_t conds [6];
        word_t   a;
        word_t   b;
        logic    taken;
        conds = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int it = 0; it < 4; it++) begin
            a = next_rand();
            b = (it == 0) ? a : next_rand();   // first round hits the equal case
            write_reg(5'd20, a);
            write_reg(5'd21, b);
            foreach (conds[k]) begin
                present(32'h3000, enc_b(13'h1ff0, 5'd21, 5'd20, conds[k]));
                taken = branch_taken(conds[k], a, b);
                check_bit("jmp_valid_o", jmp_valid, taken);
                if (taken)
                    check_word("jmp_addr_o", jmp_addr, 32'h2ff0);
                next_cycle();
            end
        end
    endtask

    task automatic test_memory();
        id_out_t exp;
        word_t   ir_v;
        ir_v = enc_i(12'd12, 5'd5, 3'b010, 5'd15, OP_LOAD);
        present(32'h400, ir_v);
        next_cycle();
        exp = expected_out(32'h400, ir_v, model[5], 32'd12, ALU_ADD, WB_SRC_MEM);
        exp.ma_mode = MA_LOAD;
        exp.ma_size = 3'b010;
        check_out("out_o", dut_out, exp);
        ir_v = enc_s(12'd20, 5'd6, 5'd5, 3'b010);
        present(32'h404, ir_v);
        next_cycle();
        exp = expected_out(32'h404, ir_v, model[5], 32'd20, ALU_ADD, WB_SRC_X);
        exp.ma_mode = MA_STORE;
        exp.ma_size = 3'b010;
        check_out("out_o", dut_out, exp);
        check_word("out_o.ma_data", dut_out.ma_data, model[6]);
        present(32'h408, 32'h0000_0073);   // ecall
        next_cycle();
        check_bit("out_o.halt", dut_out.halt, 1'b1);
        check_bit("out_o.wb_valid", dut_out.wb_valid, 1'b0);
        present(32'h40c, 32'h0000_007f);   // no such opcode
        next_cycle();
        check_bit("out_o.halt", dut_out.halt, 1'b1);
        present(32'h410, NOP_IR);
        next_cycle();
    endtask

    initial begin
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAIL");
        $finish;
    end

    initial begin
        clk = 1'b0;
        reset = 1'b1;
        pc = NOP_PC;
        ir = NOP_IR;
        ex_fwd = '0;
        ma_fwd = '0;
        wb = '0;
        test_reset();
        fill_regs();
        test_alu();
        test_forwarding();
        test_hazard();
        test_jumps();
        test_branches();
        test_memory();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: rv_id_stage.f
hw/rv_isa_pkg.sv
hw/id_ctrl_pkg.sv
hw/id_decoder.sv
hw/id_regfile.sv
hw/id_operand_bypass.sv
hw/id_branch_unit.sv
hw/id_issue.sv
hw/id_stage.sv
tests/id_stage_tb.sv

// File: Bender.yml
package:
  name: rv_id_stage

dependencies: {}

sources:
  - hw/rv_isa_pkg.sv
  - hw/id_ctrl_pkg.sv
  - hw/id_decoder.sv
  - hw/id_regfile.sv
  - hw/id_operand_bypass.sv
  - hw/id_branch_unit.sv
  - hw/id_issue.sv
  - hw/id_stage.sv
  - target: test
    files:
      - tests/id_stage_tb.sv
